// File: verification/rs_patterns.txt
// test_kind_op_tag_s1rdy_s1tag_s2rdy_s2tag_s1data_s2data_imm_expected
// kind 1 dispatch, 2 CDB (s1rdy set: same cycle as next dispatch), 3 idle, 4 flush,
// 5 check empty, 6 check full; CDB and idle take their value from s1data
// Register ops, immediate forms and LUI with ready sources
1_1_00_0_1_0_1_0_7fffffff_00000001_00000000_80000000
1_1_01_1_1_0_1_0_00000005_00000007_00000000_fffffffe
1_1_02_2_1_0_1_0_f0f0f0f0_0ff00ff0_00000000_00f000f0
1_1_03_3_1_0_1_0_f0f0f0f0_0ff00ff0_00000000_fff0fff0
1_1_04_4_1_0_1_0_f0f0f0f0_0ff00ff0_00000000_ff00ff00
1_1_05_5_1_0_1_0_00000003_00000024_00000000_00000030
1_1_06_6_1_0_1_0_80000000_0000003f_00000000_00000001
1_1_07_7_1_0_1_0_80000000_00000004_00000000_f8000000
1_1_08_8_1_0_1_0_ffffffff_00000001_00000000_00000001
1_1_09_9_1_0_1_0_ffffffff_00000001_00000000_00000000
1_1_0a_a_1_0_0_f_00000010_deadbeef_fffffff1_00000001
1_1_0b_b_1_0_0_f_12345678_deadbeef_000000ff_00000078
1_1_0c_c_1_0_0_f_12345600_deadbeef_00000078_12345678
1_1_0d_d_1_0_0_f_aaaaaaaa_deadbeef_ffffffff_55555555
1_1_0e_e_1_0_0_f_00000001_deadbeef_0000001f_80000000
1_1_0f_f_1_0_0_f_f0000000_deadbeef_00000004_0f000000
1_1_10_0_1_0_0_f_f0000000_deadbeef_00000004_ff000000
1_1_11_1_1_0_0_f_fffffffe_deadbeef_00000003_00000001
1_1_12_2_1_0_0_f_fffffffe_deadbeef_00000003_00000000
1_1_13_3_0_e_0_f_11111111_deadbeef_12345000_12345000
1_5_00_0_0_0_0_0_00000000_00000000_00000000_00000000
// Wakeup from the CDB, one broadcast in the dispatch cycle
2_1_00_0_0_8_1_0_00000000_00000005_00000000_00001005
2_1_01_1_1_0_0_9_00000100_00000000_00000000_000000ff
2_1_04_2_0_8_0_a_00000000_00000000_00000000_0000efff
2_2_00_8_0_0_0_0_00001000_00000000_00000000_00000000
2_2_00_9_1_0_0_0_00000001_00000000_00000000_00000000
2_1_03_3_0_9_1_0_00000000_00000f00_00000000_00000f01
2_2_00_a_0_0_0_0_0000ffff_00000000_00000000_00000000
2_5_00_0_0_0_0_0_00000000_00000000_00000000_00000000
// Four waiting slots fill the station, the fifth waits for a free slot
3_1_00_0_0_c_1_0_00000000_00000001_00000000_00000101
3_1_00_1_0_d_1_0_00000000_00000002_00000000_00000202
3_1_00_2_0_d_1_0_00000000_00000003_00000000_00000203
3_1_00_3_0_d_1_0_00000000_00000004_00000000_00000204
3_6_00_0_0_0_0_0_00000000_00000000_00000000_00000000
3_2_00_c_0_0_0_0_00000100_00000000_00000000_00000000
3_1_00_4_1_0_1_0_00000010_00000020_00000000_00000030
3_2_00_d_0_0_0_0_00000200_00000000_00000000_00000000
3_5_00_0_0_0_0_0_00000000_00000000_00000000_00000000
// Flush of waiting slots, then their sources are broadcast
4_1_00_5_0_8_1_0_00000000_00000001_00000000_00000000
4_1_02_6_0_9_0_a_00000000_00000000_00000000_00000000
4_4_00_0_0_0_0_0_00000000_00000000_00000000_00000000
4_5_00_0_0_0_0_0_00000000_00000000_00000000_00000000
4_2_00_8_0_0_0_0_00000011_00000000_00000000_00000000
4_2_00_9_0_0_0_0_00000022_00000000_00000000_00000000
4_2_00_a_0_0_0_0_00000033_00000000_00000000_00000000
4_3_00_0_0_0_0_0_00000008_00000000_00000000_00000000
4_5_00_0_0_0_0_0_00000000_00000000_00000000_00000000
// Independent and dependent work mixed
5_1_00_0_0_b_1_0_00000000_00000001_00000000_00001001
5_1_01_1_1_0_1_0_00000050_00000010_00000000_00000040
5_1_02_2_1_0_0_c_000000ff_00000000_00000000_0000000f
5_1_05_3_1_0_1_0_00000001_00000008_00000000_00000100
5_2_00_b_0_0_0_0_00001000_00000000_00000000_00000000
5_2_00_c_0_0_0_0_00000f0f_00000000_00000000_00000000
5_5_00_0_0_0_0_0_00000000_00000000_00000000_00000000

// File: all.f
+incdir+common
common/rs_pkg.sv
rs/rs_dispatch.sv
rs/rs_entry.sv
rs/rs_issue_select.sv
rtl/int_alu.sv
rtl/rs_top.sv
verification/rs_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := rs_tb
FILELIST  := all.f
OBJ_DIR   := obj_dir
LOG       := sim.log

SHELL := /bin/bash

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	set -o pipefail; ./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF '** FAIL **' $(LOG); then echo "Simulation reported failure"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verification/rs_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rs_tb;

    localparam int CLK_PERIOD    = 40;
    localparam int RECORD_CYCLES = 60;  // Watchdog budget per pattern record.
    localparam int MAX_RECORDS   = 64;

    logic             clk_in = 1'b0;
    logic             rst_in;
    logic             flush;
    logic             dispatch_valid;
    rs_pkg::inst_op_t dispatch_op;
    rs_pkg::tag_t     dispatch_tag;
    rs_pkg::data_t    dispatch_imm;
    logic             src1_ready;
    rs_pkg::data_t    src1_data;
    rs_pkg::tag_t     src1_tag;
    logic             src2_ready;
    rs_pkg::data_t    src2_data;
    rs_pkg::tag_t     src2_tag;
    logic             cdb_valid;
    rs_pkg::tag_t     cdb_tag;
    rs_pkg::data_t    cdb_data;
    logic             rs_full;
    logic             result_valid;
    rs_pkg::tag_t     result_tag;
    rs_pkg::data_t    result_data;

    // Test, kind, op, tag, s1 ready/tag, s2 ready/tag, s1 data, s2 data, imm, expected.
    logic [163:0]  patterns [MAX_RECORDS];
    logic          pending [16];    // Dispatched, result not seen yet.
    rs_pkg::data_t expected [16];
    logic          waits1 [16];     // Source still waiting on a broadcast.
    logic          waits2 [16];
    rs_pkg::tag_t  wait_tag1 [16];
    rs_pkg::tag_t  wait_tag2 [16];
    logic [31:0]   lfsr_state = 32'he87debf6;
    logic          joined = 1'b0;   // Broadcast held for the next dispatch cycle.
    rs_pkg::tag_t  join_tag;
    rs_pkg::data_t join_data;
    int            n_records = 0;
    int            cur_test = 0;
    int            n_tests = 0;
    int            n_checks = 0;
    int            n_errors = 0;
    int            check_mark = 0;
    int            error_mark = 0;
    int            n_pending = 0;
    int            n_dispatched = 0;
    int            n_flushed = 0;
    int            n_results = 0;

    rs_top u_dut (.*);

    always #(CLK_PERIOD / 2) clk_in = ~clk_in;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32, 22, 2, 1.
    endfunction

    task automatic random_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = v * 2 + (lfsr_state[0] ? 1 : 0);
        end
    endtask

    function automatic string test_name(input int id);
        case (id)
            1:       return "alu_ops";
            2:       return "cdb_wakeup";
            3:       return "full_stall";
            4:       return "flush";
            5:       return "out_of_order";
            default: return "unknown";
        endcase
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        n_checks++;
        if (exp !== act) begin
            $display("[FAIL] %s %s: expected %h, actual %h", test_name(cur_test), what, exp, act);
            n_errors++;
        end
    endtask

    task automatic report_test(input int id);
        $display("Test %0d %s: %s (%0d checks, %0d errors)", id, test_name(id),
                 (n_errors == error_mark) ? "passed" : "failed",
                 n_checks - check_mark, n_errors - error_mark);
        n_tests++;
        check_mark = n_checks;
        error_mark = n_errors;
    endtask

    task automatic note_broadcast(input rs_pkg::tag_t t);
        for (int i = 0; i < 16; i++) begin
            if (waits1[i] && wait_tag1[i] == t) waits1[i] = 1'b0;
            if (waits2[i] && wait_tag2[i] == t) waits2[i] = 1'b0;
        end
    endtask

    task automatic send_dispatch(input logic [163:0] r);
        rs_pkg::tag_t t;
        logic [7:0]   op;
        t  = r[147:144];
        op = r[155:148];
        while (pending[t] || rs_full) @(negedge clk_in);  // Held off while full.
        dispatch_valid = 1'b1;
        dispatch_op    = rs_pkg::inst_op_t'(op[5:0]);
        dispatch_tag   = t;
        src1_ready     = r[140];
        src1_tag       = r[139:136];
        src2_ready     = r[132];
        src2_tag       = r[131:128];
        src1_data      = r[127:96];
        src2_data      = r[95:64];
        dispatch_imm   = r[63:32];
        pending[t]   = 1'b1;
        expected[t]  = r[31:0];
        waits1[t]    = !r[140] && (op != 8'h13);  // LUI takes zero as operand 1.
        waits2[t]    = !r[132] && (op < 8'h0a);   // Immediate forms take the imm.
        wait_tag1[t] = r[139:136];
        wait_tag2[t] = r[131:128];
        n_pending++;
        n_dispatched++;
        if (joined) begin
            cdb_valid = 1'b1;
            cdb_tag   = join_tag;
            cdb_data  = join_data;
            note_broadcast(join_tag);
            joined = 1'b0;
        end
        @(negedge clk_in);
        dispatch_valid = 1'b0;
        cdb_valid      = 1'b0;
    endtask

    task automatic send_broadcast(input logic [163:0] r);
        if (r[140]) begin
            joined    = 1'b1;
            join_tag  = r[147:144];
            join_data = r[127:96];
        end else begin
            cdb_valid = 1'b1;
            cdb_tag   = r[147:144];
            cdb_data  = r[127:96];
            note_broadcast(r[147:144]);
            @(negedge clk_in);
            cdb_valid = 1'b0;
        end
    endtask

    task automatic send_flush();
        flush = 1'b1;
        @(negedge clk_in);
        flush = 1'b0;
        for (int i = 0; i < 16; i++) begin
            if (pending[i]) n_flushed++;
            pending[i] = 1'b0;
            waits1[i]  = 1'b0;
            waits2[i]  = 1'b0;
        end
        n_pending = 0;
    endtask

    task automatic check_empty();
        while (n_pending != 0) @(negedge clk_in);
        check_value("rs_full when empty", 32'd0, 32'(rs_full));
    endtask

    always @(posedge clk_in) begin
        if (!rst_in && result_valid) begin
            if (!pending[result_tag]) begin
                $display("Unexpected result for tag %0d in test %s", result_tag,
                         test_name(cur_test));
                n_errors++;
            end else begin
                if (waits1[result_tag] || waits2[result_tag]) begin
                    $display("Tag %0d returned before its source was broadcast", result_tag);
                    n_errors++;
                end
                check_value($sformatf("result tag %0d", result_tag), expected[result_tag],
                            result_data);
                pending[result_tag] = 1'b0;
                n_pending--;
                n_results++;
            end
        end
    end

    initial begin
        wait (n_records > 0);
        #(n_records * RECORD_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles",
                 n_records * RECORD_CYCLES);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        logic [163:0] rec;
        int           gap;
        rst_in         = 1'b1;
        flush          = 1'b0;
        dispatch_valid = 1'b0;
        dispatch_op    = rs_pkg::INST_ADD;
        dispatch_tag   = '0;
        dispatch_imm   = '0;
        src1_ready     = 1'b0;
        src1_data      = '0;
        src1_tag       = '0;
        src2_ready     = 1'b0;
        src2_data      = '0;
        src2_tag       = '0;
        cdb_valid      = 1'b0;
        cdb_tag        = '0;
        cdb_data       = '0;
        for (int i = 0; i < 16; i++) begin
            pending[i] = 1'b0;
            waits1[i]  = 1'b0;
            waits2[i]  = 1'b0;
        end
        for (int i = 0; i < MAX_RECORDS; i++) patterns[i] = '0;
        $readmemh("verification/rs_patterns.txt", patterns);
        while (n_records < MAX_RECORDS && patterns[n_records][159:156] != 4'h0) n_records++;
        if (n_records == 0) begin
            $display("No pattern records were loaded");
            n_errors++;
        end
        repeat (4) @(posedge clk_in);
        @(negedge clk_in);
        rst_in = 1'b0;

        for (int i = 0; i < n_records; i++) begin
            rec = patterns[i];
            if (int'(rec[163:160]) != cur_test) begin
                if (cur_test != 0) report_test(cur_test);
                cur_test = int'(rec[163:160]);
            end
            case (rec[159:156])
                4'h1:    send_dispatch(rec);
                4'h2:    send_broadcast(rec);
                4'h3:    repeat (rec[127:96]) @(negedge clk_in);
                4'h4:    send_flush();
                4'h5:    check_empty();
                4'h6:    check_value("rs_full when full", 32'd1, 32'(rs_full));
                default: begin
                    $display("Record %0d has an unknown kind", i);
                    n_errors++;
                end
            endcase
            if (!joined) begin
                random_bits(2, gap);
                repeat (gap) @(negedge clk_in);
            end
        end

        check_value("result count", n_dispatched - n_flushed, n_results);
        if (cur_test != 0) report_test(cur_test);
        $display("Summary: %0d tests, %0d checks, %0d errors, %0d results, %0d flushed",
                 n_tests, n_checks, n_errors, n_results, n_flushed);
        if (n_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/rs_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "rs_macros.svh"

module rs_top (
    input  wire                    clk_in,
    input  wire                    rst_in,
    input  wire                    flush,
    input  wire                    dispatch_valid,
    input  wire rs_pkg::inst_op_t  dispatch_op,
    input  wire rs_pkg::tag_t      dispatch_tag,
    input  wire rs_pkg::data_t     dispatch_imm,
    input  wire                    src1_ready,
    input  wire rs_pkg::data_t     src1_data,
    input  wire rs_pkg::tag_t      src1_tag,
    input  wire                    src2_ready,
    input  wire rs_pkg::data_t     src2_data,
    input  wire rs_pkg::tag_t      src2_tag,
    input  wire                    cdb_valid,
    input  wire rs_pkg::tag_t      cdb_tag,
    input  wire rs_pkg::data_t     cdb_data,
    output logic                   rs_full,
    output logic                   result_valid,
    output rs_pkg::tag_t           result_tag,
    output rs_pkg::data_t          result_data
);

    logic [`RS_ENTRIES-1:0] alloc;
    logic [`RS_ENTRIES-1:0] busy;
    logic [`RS_ENTRIES-1:0] ready;
    logic [`RS_ENTRIES-1:0] grant;
    rs_pkg::alu_op_t        alu_op;
    logic                   op1_ready;
    rs_pkg::data_t          op1_data;
    rs_pkg::tag_t           op1_tag;
    logic                   op2_ready;
    rs_pkg::data_t          op2_data;
    rs_pkg::tag_t           op2_tag;
    rs_pkg::alu_op_t        slot_op  [`RS_ENTRIES];
    rs_pkg::data_t          slot_a   [`RS_ENTRIES];
    rs_pkg::data_t          slot_b   [`RS_ENTRIES];
    rs_pkg::tag_t           slot_tag [`RS_ENTRIES];
    logic                   issue_valid;
    rs_pkg::alu_op_t        issue_op;
    rs_pkg::data_t          issue_a;
    rs_pkg::data_t          issue_b;
    rs_pkg::tag_t           issue_tag;

    rs_dispatch u_dispatch (
        .clk_in, .rst_in, .flush,
        .dispatch_valid, .dispatch_op, .dispatch_imm,
        .src1_ready, .src1_data, .src1_tag,
        .src2_ready, .src2_data, .src2_tag,
        .busy, .alloc, .alu_op,
        .op1_ready, .op1_data, .op1_tag,
        .op2_ready, .op2_data, .op2_tag,
        .rs_full
    );

    for (genvar i = 0; i < `RS_ENTRIES; i++) begin : g_slot
        rs_entry u_entry (
            .clk_in, .rst_in, .flush,
            .alloc(alloc[i]), .grant(grant[i]),
            .alu_op, .dispatch_tag,
            .op1_ready, .op1_data, .op1_tag,
            .op2_ready, .op2_data, .op2_tag,
            .cdb_valid, .cdb_tag, .cdb_data,
            .busy(busy[i]), .ready(ready[i]),
            .slot_op(slot_op[i]), .slot_a(slot_a[i]),
            .slot_b(slot_b[i]), .slot_tag(slot_tag[i])
        );
    end

    rs_issue_select u_select (
        .clk_in, .rst_in, .flush, .ready,
        .slot_op, .slot_a, .slot_b, .slot_tag, .grant,
        .issue_valid, .issue_op, .issue_a, .issue_b, .issue_tag
    );

    int_alu u_alu (
        .clk_in, .rst_in,
        .issue_valid, .issue_op, .issue_a, .issue_b, .issue_tag,
        .result_valid, .result_tag, .result_data
    );

endmodule

`default_nettype wire

// File: rtl/int_alu.sv
`timescale 1ns/1ps
`default_nettype none

module int_alu (
    input  wire                   clk_in,
    input  wire                   rst_in,
    input  wire                   issue_valid,
    input  wire rs_pkg::alu_op_t  issue_op,
    input  wire rs_pkg::data_t    issue_a,
    input  wire rs_pkg::data_t    issue_b,
    input  wire rs_pkg::tag_t     issue_tag,
    output logic                  result_valid,
    output rs_pkg::tag_t          result_tag,
    output rs_pkg::data_t         result_data
);

    logic [4:0]    shamt;
    rs_pkg::data_t alu_out;

    assign shamt = issue_b[4:0];  // RV32 shift amount.

    always_comb begin
        case (issue_op)
            rs_pkg::ALU_ADD:  alu_out = issue_a + issue_b;
            rs_pkg::ALU_SUB:  alu_out = issue_a - issue_b;
            rs_pkg::ALU_AND:  alu_out = issue_a & issue_b;
            rs_pkg::ALU_OR:   alu_out = issue_a | issue_b;
            rs_pkg::ALU_XOR:  alu_out = issue_a ^ issue_b;
            rs_pkg::ALU_SLL:  alu_out = issue_a << shamt;
            rs_pkg::ALU_SRL:  alu_out = issue_a >> shamt;
            rs_pkg::ALU_SRA:  alu_out = rs_pkg::data_t'($signed(issue_a) >>> shamt);
            rs_pkg::ALU_SLT:  alu_out = rs_pkg::data_t'($signed(issue_a) < $signed(issue_b));
            rs_pkg::ALU_SLTU: alu_out = rs_pkg::data_t'(issue_a < issue_b);
            default:          alu_out = '0;
        endcase
    end

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk_in) begin
        if (issue_valid) begin
            result_tag  <= issue_tag;
            result_data <= alu_out;
        end
    end

endmodule

`default_nettype wire

// File: rs/rs_issue_select.sv
`timescale 1ns/1ps
`default_nettype none
`include "rs_macros.svh"

module rs_issue_select (
    input  wire                    clk_in,
    input  wire                    rst_in,
    input  wire                    flush,
    input  wire [`RS_ENTRIES-1:0]  ready,
    input  wire rs_pkg::alu_op_t   slot_op  [`RS_ENTRIES],
    input  wire rs_pkg::data_t     slot_a   [`RS_ENTRIES],
    input  wire rs_pkg::data_t     slot_b   [`RS_ENTRIES],
    input  wire rs_pkg::tag_t      slot_tag [`RS_ENTRIES],
    output logic [`RS_ENTRIES-1:0] grant,
    output logic                   issue_valid,
    output rs_pkg::alu_op_t        issue_op,
    output rs_pkg::data_t          issue_a,
    output rs_pkg::data_t          issue_b,
    output rs_pkg::tag_t           issue_tag
);

    rs_pkg::slot_idx_t sel;
    logic              issue_q;

    assign grant = ready & (~ready + 1'b1);  // Lowest ready slot wins.

    always_comb begin
        sel = '0;
        for (int i = `RS_ENTRIES - 1; i >= 0; i--) begin
            if (ready[i]) sel = rs_pkg::slot_idx_t'(i);
        end
    end

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            issue_q <= 1'b0;
        end else begin
            issue_q <= (|ready) && !flush;
        end
    end

    always_ff @(posedge clk_in) begin
        issue_op  <= slot_op[sel];
        issue_a   <= slot_a[sel];
        issue_b   <= slot_b[sel];
        issue_tag <= slot_tag[sel];
    end

    assign issue_valid = issue_q && !flush;  // Drop an issue caught by flush.

    // The granted slot is the one whose operands the mux passes on.
    a_grant_onehot: assert property (
        @(posedge clk_in) disable iff (rst_in)
        (|ready) |-> ($onehot(grant) && grant[sel]));

endmodule

`default_nettype wire

// File: rs/rs_entry.sv
`timescale 1ns/1ps
`default_nettype none

module rs_entry (
    input  wire                    clk_in,
    input  wire                    rst_in,
    input  wire                    flush,
    input  wire                    alloc,
    input  wire                    grant,
    input  wire rs_pkg::alu_op_t   alu_op,
    input  wire rs_pkg::tag_t      dispatch_tag,
    input  wire                    op1_ready,
    input  wire rs_pkg::data_t     op1_data,
    input  wire rs_pkg::tag_t      op1_tag,
    input  wire                    op2_ready,
    input  wire rs_pkg::data_t     op2_data,
    input  wire rs_pkg::tag_t      op2_tag,
    input  wire                    cdb_valid,
    input  wire rs_pkg::tag_t      cdb_tag,
    input  wire rs_pkg::data_t     cdb_data,
    output logic                   busy,
    output logic                   ready,
    output rs_pkg::alu_op_t        slot_op,
    output rs_pkg::data_t          slot_a,
    output rs_pkg::data_t          slot_b,
    output rs_pkg::tag_t           slot_tag
);

    logic         a_ready;
    logic         b_ready;
    rs_pkg::tag_t a_tag;     // Producer tags of waiting sources.
    rs_pkg::tag_t b_tag;
    logic         op1_hit;
    logic         op2_hit;
    logic         a_hit;
    logic         b_hit;

    // A source may be produced in the very cycle it is dispatched.
    assign op1_hit = cdb_valid && (cdb_tag == op1_tag);
    assign op2_hit = cdb_valid && (cdb_tag == op2_tag);

    assign a_hit = busy && !a_ready && cdb_valid && (cdb_tag == a_tag);
    assign b_hit = busy && !b_ready && cdb_valid && (cdb_tag == b_tag);

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            busy    <= 1'b0;
            a_ready <= 1'b0;
            b_ready <= 1'b0;
        end else if (flush) begin
            busy    <= 1'b0;
            a_ready <= 1'b0;
            b_ready <= 1'b0;
        end else if (alloc) begin
            busy    <= 1'b1;
            a_ready <= op1_ready || op1_hit;
            b_ready <= op2_ready || op2_hit;
        end else begin
            if (grant) begin
                busy <= 1'b0;  // Freed at issue.
            end
            if (a_hit) begin
                a_ready <= 1'b1;
            end
            if (b_hit) begin
                b_ready <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (alloc) begin
            slot_op  <= alu_op;
            slot_tag <= dispatch_tag;
            a_tag    <= op1_tag;
            b_tag    <= op2_tag;
            slot_a   <= op1_ready ? op1_data : cdb_data;
            slot_b   <= op2_ready ? op2_data : cdb_data;
        end else begin
            if (a_hit) slot_a <= cdb_data;
            if (b_hit) slot_b <= cdb_data;
        end
    end

    assign ready = busy && a_ready && b_ready;

    a_grant_needs_ready: assert property (
        @(posedge clk_in) disable iff (rst_in) grant |-> ready);

endmodule

`default_nettype wire

// File: rs/rs_dispatch.sv
`timescale 1ns/1ps
`default_nettype none
`include "rs_macros.svh"

module rs_dispatch (
    input  wire                      clk_in,
    input  wire                      rst_in,
    input  wire                      flush,
    input  wire                      dispatch_valid,
    input  wire rs_pkg::inst_op_t    dispatch_op,
    input  wire rs_pkg::data_t       dispatch_imm,
    input  wire                      src1_ready,
    input  wire rs_pkg::data_t       src1_data,
    input  wire rs_pkg::tag_t        src1_tag,
    input  wire                      src2_ready,
    input  wire rs_pkg::data_t       src2_data,
    input  wire rs_pkg::tag_t        src2_tag,
    input  wire [`RS_ENTRIES-1:0]    busy,
    output logic [`RS_ENTRIES-1:0]   alloc,
    output rs_pkg::alu_op_t          alu_op,
    output logic                     op1_ready,
    output rs_pkg::data_t            op1_data,
    output rs_pkg::tag_t             op1_tag,
    output logic                     op2_ready,
    output rs_pkg::data_t            op2_data,
    output rs_pkg::tag_t             op2_tag,
    output logic                     rs_full
);

    logic                             uses_imm;
    logic                             is_lui;
    logic [`RS_ENTRIES-1:0]           free_first;
    logic [$clog2(`RS_ENTRIES+1)-1:0] busy_now;
    logic [$clog2(`RS_ENTRIES+1)-1:0] busy_cnt;

    always_comb begin
        case (dispatch_op)
            rs_pkg::INST_ADD, rs_pkg::INST_ADDI:   alu_op = rs_pkg::ALU_ADD;
            rs_pkg::INST_SUB:                      alu_op = rs_pkg::ALU_SUB;
            rs_pkg::INST_AND, rs_pkg::INST_ANDI:   alu_op = rs_pkg::ALU_AND;
            rs_pkg::INST_OR, rs_pkg::INST_ORI:     alu_op = rs_pkg::ALU_OR;
            rs_pkg::INST_XOR, rs_pkg::INST_XORI:   alu_op = rs_pkg::ALU_XOR;
            rs_pkg::INST_SLL, rs_pkg::INST_SLLI:   alu_op = rs_pkg::ALU_SLL;
            rs_pkg::INST_SRL, rs_pkg::INST_SRLI:   alu_op = rs_pkg::ALU_SRL;
            rs_pkg::INST_SRA, rs_pkg::INST_SRAI:   alu_op = rs_pkg::ALU_SRA;
            rs_pkg::INST_SLT, rs_pkg::INST_SLTI:   alu_op = rs_pkg::ALU_SLT;
            rs_pkg::INST_SLTU, rs_pkg::INST_SLTIU: alu_op = rs_pkg::ALU_SLTU;
            default:                               alu_op = rs_pkg::ALU_ADD; // LUI is 0 + imm.
        endcase
    end

    // Immediate forms and LUI follow the register ops in the encoding.
    assign uses_imm = (dispatch_op >= rs_pkg::INST_ADDI);
    assign is_lui   = (dispatch_op == rs_pkg::INST_LUI);

    assign op1_ready = src1_ready || is_lui;
    assign op1_data  = is_lui ? '0 : src1_data;
    assign op1_tag   = src1_tag;
    assign op2_ready = src2_ready || uses_imm;
    assign op2_data  = uses_imm ? dispatch_imm : src2_data;
    assign op2_tag   = src2_tag;

    assign free_first = ~busy & (busy + 1'b1);  // Lowest clear bit of busy.
    assign alloc      = (dispatch_valid && !rs_full) ? free_first : '0;

    always_comb begin
        busy_now = '0;
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            busy_now = busy_now + busy[i];
        end
    end

    // Slots released by issue at this edge are counted again one cycle later.
    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            busy_cnt <= '0;
        end else if (flush) begin
            busy_cnt <= '0;
        end else begin
            busy_cnt <= busy_now + (|alloc);
        end
    end

    assign rs_full = (busy_cnt == `RS_ENTRIES);

    a_no_dispatch_when_full: assert property (
        @(posedge clk_in) disable iff (rst_in) rs_full |-> !dispatch_valid);

endmodule

`default_nettype wire

// File: common/rs_pkg.sv
`default_nettype none
`include "rs_macros.svh"

package rs_pkg;

    typedef logic [`RS_DATA_W-1:0] data_t;             // Operand or result value.
    typedef logic [`RS_TAG_W-1:0] tag_t;               // Reorder tag.
    typedef logic [$clog2(`RS_ENTRIES)-1:0] slot_idx_t;

    // Instruction op as handed over by the decoder.
    typedef enum logic [5:0] {
        INST_ADD = 6'd0,
        INST_SUB,
        INST_AND,
        INST_OR,
        INST_XOR,
        INST_SLL,
        INST_SRL,
        INST_SRA,
        INST_SLT,
        INST_SLTU,
        INST_ADDI,
        INST_ANDI,
        INST_ORI,
        INST_XORI,
        INST_SLLI,
        INST_SRLI,
        INST_SRAI,
        INST_SLTI,
        INST_SLTIU,
        INST_LUI
    } inst_op_t;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU
    } alu_op_t;

endpackage

`default_nettype wire

// File: common/rs_macros.svh
`ifndef RS_MACROS_SVH
`define RS_MACROS_SVH

// Reservation station sizing.
`define RS_ENTRIES 4   // Number of slots.

`define RS_DATA_W  32  // Operand and result width.

// Reorder tag width, for producer and destination tags.
`define RS_TAG_W   4

`endif
